//--- design/display_pkg.sv
// shared screen timing and bitmap constants
// packed structs for position, colour, scan events and load commands
`default_nettype none

package display_pkg;

    // 640x480 at 60 Hz, pixel clock about 25 MHz
    localparam int H_RES   = 640;
    localparam int V_RES   = 480;
    localparam int H_FP    = 16;
    localparam int H_SYNC  = 96;
    localparam int H_BP    = 48;
    localparam int V_FP    = 10;
    localparam int V_SYNC  = 2;
    localparam int V_BP    = 33;
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525
    localparam int CORDW   = 10;                            // covers 0..799

    localparam int BMP_W      = 320;
    localparam int BMP_H      = 240;
    localparam int BMP_PIXELS = BMP_W * BMP_H;
    localparam int BMP_ADDRW  = $clog2(BMP_PIXELS);  // 17
    localparam int IDXW       = 4;                   // 16 colours
    localparam int CHANW      = 4;
    localparam int SCALE      = 2;                   // same both ways
    localparam int LB_ADDRW   = $clog2(BMP_W);       // 9

    typedef struct packed {
        logic [CORDW-1:0] sx;
        logic [CORDW-1:0] sy;
        logic             de;     // visible area
        logic             hsync;  // active low
        logic             vsync;  // active low
    } screen_pos_t;

    typedef struct packed {
        logic [CHANW-1:0] r;
        logic [CHANW-1:0] g;
        logic [CHANW-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic line_start;  // sx 0 of a visible line
        logic frame_end;   // last pixel of the frame
    } scan_evt_t;

    // bitmap write: index in data[IDXW-1:0]; palette write: entry in addr[IDXW-1:0]
    typedef struct packed {
        logic                 valid;
        logic                 sel_palette;
        logic [BMP_ADDRW-1:0] addr;
        rgb_t                 data;
    } load_cmd_t;

endpackage

`default_nettype wire

//--- design/display_timing.sv
// 640x480 scan counters with registered sync, data enable
// and the line start / frame end strobes
`default_nettype none
`timescale 1ns/1ps

module display_timing (
    input  wire logic                clk_pix,
    input  wire logic                rst,
    output display_pkg::screen_pos_t pos,
    output display_pkg::scan_evt_t   evt
);
    import display_pkg::*;

    localparam int HS_START = H_RES + H_FP;       // 656
    localparam int HS_END   = HS_START + H_SYNC;  // 752, exclusive
    localparam int VS_START = V_RES + V_FP;       // 490
    localparam int VS_END   = VS_START + V_SYNC;  // 492, exclusive

    logic [CORDW-1:0] nx;  // coordinates of the coming cycle
    logic [CORDW-1:0] ny;
    logic             line_wrap;

    always_comb begin
        line_wrap = (pos.sx == CORDW'(H_TOTAL - 1));
        nx = line_wrap ? '0 : pos.sx + 1'b1;
        ny = pos.sy;
        if (line_wrap) begin
            ny = (pos.sy == CORDW'(V_TOTAL - 1)) ? '0 : pos.sy + 1'b1;
        end
    end

    // everything is decoded from nx/ny so it lines up with the coordinates
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            pos.sx         <= '0;
            pos.sy         <= '0;
            pos.de         <= 1'b0;
            pos.hsync      <= 1'b1;  // inactive
            pos.vsync      <= 1'b1;
            evt.line_start <= 1'b0;
            evt.frame_end  <= 1'b0;
        end else begin
            pos.sx <= nx;
            pos.sy <= ny;
            pos.de <= (nx < CORDW'(H_RES)) && (ny < CORDW'(V_RES));
            pos.hsync <= !((nx >= CORDW'(HS_START)) && (nx < CORDW'(HS_END)));
            pos.vsync <= !((ny >= CORDW'(VS_START)) && (ny < CORDW'(VS_END)));
            // drawing lines only
            evt.line_start <= (nx == '0) && (ny < CORDW'(V_RES));
            evt.frame_end  <= (nx == CORDW'(H_TOTAL - 1)) && (ny == CORDW'(V_TOTAL - 1));
        end
    end

endmodule

`default_nettype wire

//--- design/bitmap_store.sv
// 320x240 bitmap of colour indices, simple dual port
// load port writes, fetch stage reads with one cycle latency
`default_nettype none
`timescale 1ns/1ps

module bitmap_store (
    input  wire logic                          clk_pix,
    input  wire display_pkg::load_cmd_t        load,
    input  wire logic [display_pkg::BMP_ADDRW-1:0] rd_addr,
    output logic [display_pkg::IDXW-1:0]       rd_idx
);
    import display_pkg::*;

    logic [IDXW-1:0] mem [BMP_PIXELS];  // block ram
    logic            bmp_we;

    // palette writes share the bus, so filter them out
    always_comb begin
        bmp_we = load.valid && !load.sel_palette;
    end

    always_ff @(posedge clk_pix) begin
        if (bmp_we) begin
            mem[load.addr] <= load.data[IDXW-1:0];  // index in low bits
        end
    end

    // registered read
    always_ff @(posedge clk_pix) begin
        rd_idx <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- design/colour_lut.sv
// 16-entry palette, index to 12-bit rgb
// written from the load port, registered lookup
`default_nettype none
`timescale 1ns/1ps

module colour_lut (
    input  wire logic                       clk_pix,
    input  wire display_pkg::load_cmd_t     load,
    input  wire logic [display_pkg::IDXW-1:0] idx,
    output display_pkg::rgb_t               colour
);
    import display_pkg::*;

    rgb_t palette [2**IDXW];  // small, maps to distributed ram
    logic pal_we;

    always_comb begin
        pal_we = load.valid && load.sel_palette;
    end

    // entry number sits in the low address bits
    always_ff @(posedge clk_pix) begin
        if (pal_we) begin
            palette[load.addr[IDXW-1:0]] <= load.data;
        end
    end

    // one cycle lookup
    always_ff @(posedge clk_pix) begin
        colour <= palette[idx];
    end

endmodule

`default_nettype wire

//--- design/line_fetch.sv
// bitmap row fetch sequencer, one row per two screen lines
// plus the delay line that aligns line-buffer writes with palette output
`default_nettype none
`timescale 1ns/1ps

module line_fetch (
    input  wire logic                              clk_pix,
    input  wire logic                              rst,
    input  wire display_pkg::screen_pos_t          pos,
    input  wire display_pkg::scan_evt_t            evt,
    output logic [display_pkg::BMP_ADDRW-1:0]      bmp_addr,
    output logic                                   lb_we,
    output logic [display_pkg::LB_ADDRW-1:0]       lb_addr,
    output logic                                   lb_bank
);
    import display_pkg::*;

    logic                row0_start;   // last blank line, fetches row 0
    logic                fetch_start;  // a fresh row is due for the next line pair
    logic                fetch_en;     // burst running
    logic [LB_ADDRW-1:0] col;          // column of the address being issued
    logic                bank;         // bank of the row being fetched

    // two stage delay: bitmap read, then palette lookup
    logic [1:0]          we_d;
    logic [LB_ADDRW-1:0] addr_d [2];
    logic [1:0]          bank_d;

    // row r is fetched during screen line 2r-1
    always_comb begin
        row0_start  = (pos.sy == CORDW'(V_TOTAL - 1)) && (pos.sx == '0);
        fetch_start = (evt.line_start && pos.sy[0] && (pos.sy < CORDW'(V_RES - 1)))
                      || row0_start;
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            fetch_en <= 1'b0;
            col      <= '0;
            bmp_addr <= '0;
            bank     <= 1'b0;
        end else if (evt.frame_end) begin
            fetch_en <= 1'b0;  // resync, no burst crosses the frame edge
            col      <= '0;
        end else if (fetch_start) begin
            fetch_en <= 1'b1;
            col      <= '0;
            if (row0_start) begin
                bmp_addr <= '0;    // top of the bitmap
                bank     <= 1'b0;  // row 0 into bank 0
            end else begin
                bank <= ~bank;     // alternate banks row by row
            end
        end else if (fetch_en) begin
            bmp_addr <= bmp_addr + 1'b1;  // running address, rows are contiguous
            col      <= col + 1'b1;
            if (col == LB_ADDRW'(BMP_W - 1)) begin
                fetch_en <= 1'b0;  // 320 reads done
            end
        end
    end

    // write strobe must be cleared by reset
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            we_d <= '0;
        end else begin
            we_d <= {we_d[0], fetch_en};
        end
    end

    always_ff @(posedge clk_pix) begin
        addr_d[0] <= col;
        addr_d[1] <= addr_d[0];
        bank_d    <= {bank_d[0], bank};
    end

    // meets colour_lut output, line buffer registers the write
    assign lb_we   = we_d[1];
    assign lb_addr = addr_d[1];
    assign lb_bank = bank_d[1];

endmodule

`default_nettype wire

//--- design/line_buffer.sv
// ping-pong rgb line store, two banks of 320 pixels
// read side scales by two horizontally and blanks outside de
`default_nettype none
`timescale 1ns/1ps

module line_buffer (
    input  wire logic                          clk_pix,
    input  wire display_pkg::screen_pos_t      pos,
    input  wire logic                          we,
    input  wire logic [display_pkg::LB_ADDRW-1:0] wr_addr,
    input  wire logic                          wr_bank,
    input  wire display_pkg::rgb_t             wr_rgb,
    output display_pkg::rgb_t                  rgb
);
    import display_pkg::*;

    rgb_t                     mem [2][BMP_W];
    rgb_t                     rd_data;
    logic [LB_ADDRW-1:0]      rd_addr;     // runs one pixel ahead of sx
    logic [$clog2(SCALE)-1:0] scale_cnt;   // screen pixels per bitmap pixel
    logic                     rd_bank;
    logic [CORDW-1:0]         next_sy;     // line that starts after sx 799
    logic [CORDW-1:0]         next_row;

    // fetch side
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[wr_bank][wr_addr] <= wr_rgb;
        end
    end

    always_comb begin
        next_sy  = (pos.sy == CORDW'(V_TOTAL - 1)) ? '0 : pos.sy + 1'b1;
        next_row = next_sy / CORDW'(SCALE);
    end

    // pre-load at sx 798 so the first pixel is out at sx 0
    always_ff @(posedge clk_pix) begin
        if (pos.sx == CORDW'(H_TOTAL - 2)) begin
            rd_addr   <= '0;
            scale_cnt <= '0;
            // bank 1 is idle while row 0 is written on the last blank line
            rd_bank <= (next_sy < CORDW'(V_RES)) ? next_row[0] : 1'b1;
        end else if (rd_addr < LB_ADDRW'(BMP_W - 1)) begin
            if (scale_cnt == SCALE - 1) begin
                scale_cnt <= '0;
                rd_addr   <= rd_addr + 1'b1;
            end else begin
                scale_cnt <= scale_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_bank][rd_addr];  // registered read
    end

    // black in the porches and sync
    always_comb begin
        rgb = pos.de ? rd_data : '0;
    end

endmodule

`default_nettype wire

//--- design/display_top.sv
// bitmap display engine top level
// timing, row fetch, bitmap ram, palette and line buffer
`default_nettype none
`timescale 1ns/1ps

module display_top (
    input  wire logic                   clk_pix,
    input  wire logic                   rst,
    input  wire display_pkg::load_cmd_t load,   // bitmap and palette fill
    output display_pkg::screen_pos_t    pos,    // vga sync and position
    output display_pkg::rgb_t           rgb
);
    import display_pkg::*;

    scan_evt_t            evt;
    logic [BMP_ADDRW-1:0] bmp_addr;
    logic [IDXW-1:0]      idx;       // one cycle after bmp_addr
    rgb_t                 colour;    // two cycles after bmp_addr
    logic                 lb_we;
    logic [LB_ADDRW-1:0]  lb_addr;
    logic                 lb_bank;

    display_timing i_timing (
        .clk_pix,
        .rst,
        .pos,
        .evt
    );

    line_fetch i_fetch (
        .clk_pix,
        .rst,
        .pos,
        .evt,
        .bmp_addr,
        .lb_we,
        .lb_addr,
        .lb_bank
    );

    bitmap_store i_bitmap (
        .clk_pix,
        .load,
        .rd_addr (bmp_addr),
        .rd_idx  (idx)
    );

    colour_lut i_palette (
        .clk_pix,
        .load,
        .idx,
        .colour
    );

    // write side lines up with colour via the fetch delay line
    line_buffer i_line_buffer (
        .clk_pix,
        .pos,
        .we      (lb_we),
        .wr_addr (lb_addr),
        .wr_bank (lb_bank),
        .wr_rgb  (colour),
        .rgb
    );

endmodule

`default_nettype wire

//--- sim/display_asserts.sv
// concurrent checks on scan timing, bound into display_timing
// sync windows, data enable area, frame end strobe
`default_nettype none
`timescale 1ns/1ps

module display_asserts (
    input wire logic                     clk_pix,
    input wire logic                     rst,
    input wire display_pkg::screen_pos_t pos,
    input wire display_pkg::scan_evt_t   evt
);
    import display_pkg::*;

    int fail_count = 0;  // failures seen, polled by the testbench

    // hsync low on sx 656..751 and nowhere else
    hsync_window: assert property (@(posedge clk_pix) disable iff (rst)
        !pos.hsync == ((pos.sx >= CORDW'(H_RES + H_FP)) &&
                       (pos.sx <  CORDW'(H_RES + H_FP + H_SYNC))))
    else begin
        $error("hsync level wrong at sx %0d", pos.sx);
        fail_count++;
    end

    // de only inside the visible area
    de_visible: assert property (@(posedge clk_pix) disable iff (rst)
        pos.de |-> (pos.sx < CORDW'(H_RES)) && (pos.sy < CORDW'(V_RES)))
    else begin
        $error("de high outside the visible area at %0d,%0d", pos.sx, pos.sy);
        fail_count++;
    end

    frame_end_once: assert property (@(posedge clk_pix) disable iff (rst)
        evt.frame_end |=> !evt.frame_end)  // single cycle strobe
    else begin
        $error("frame_end held for more than one cycle");
        fail_count++;
    end

endmodule

bind display_timing display_asserts i_asserts (.*);

`default_nettype wire

//--- sim/display_tb.sv
// testbench for the bitmap display engine
// random image and palette load, probe pixel table, scan timing counts
`default_nettype none
`timescale 1ns/1ps

module display_tb;
    import display_pkg::*;

    typedef struct packed {
        logic [1:0]       frame;    // counted from 1 after reset
        logic [CORDW-1:0] sx;
        logic [CORDW-1:0] sy;
        logic             pair;     // same colour as the entry before
        logic             rewrite;  // palette rewrite here, no compare
    } probe_t;

    localparam int LOAD_CYCLES    = 2**IDXW + BMP_PIXELS;
    localparam int TIMEOUT_CYCLES = 3 * H_TOTAL * V_TOTAL + LOAD_CYCLES + 10000;
    localparam int N_PROBES       = 19;

    // probe points, scan order within each frame
    localparam probe_t PROBES [N_PROBES] = '{
        '{2'd2, 10'd0,   10'd0,   1'b0, 1'b0},  // top left corner
        '{2'd2, 10'd1,   10'd0,   1'b1, 1'b0},  // horizontal pair
        '{2'd2, 10'd639, 10'd0,   1'b0, 1'b0},  // top right corner
        '{2'd2, 10'd640, 10'd0,   1'b0, 1'b0},  // front porch, black
        '{2'd2, 10'd0,   10'd1,   1'b0, 1'b0},  // second line of row 0
        '{2'd2, 10'd100, 10'd2,   1'b0, 1'b0},  // bank 1 takes over
        '{2'd2, 10'd101, 10'd2,   1'b1, 1'b0},
        '{2'd2, 10'd101, 10'd3,   1'b1, 1'b0},  // vertical pair
        '{2'd2, 10'd51,  10'd4,   1'b0, 1'b0},  // back to bank 0
        '{2'd2, 10'd320, 10'd240, 1'b0, 1'b0},
        '{2'd2, 10'd321, 10'd241, 1'b1, 1'b0},
        '{2'd2, 10'd639, 10'd479, 1'b0, 1'b0},  // bottom right corner
        '{2'd2, 10'd640, 10'd479, 1'b0, 1'b0},
        '{2'd2, 10'd320, 10'd490, 1'b0, 1'b0},  // vsync, black
        '{2'd2, 10'd0,   10'd500, 1'b0, 1'b1},  // palette rewrite in vblank
        '{2'd2, 10'd799, 10'd524, 1'b0, 1'b0},
        '{2'd3, 10'd0,   10'd0,   1'b0, 1'b0},  // new colour expected
        '{2'd3, 10'd1,   10'd1,   1'b1, 1'b0},
        '{2'd3, 10'd639, 10'd479, 1'b0, 1'b0}
    };

    logic        clk_pix;
    logic        rst;
    load_cmd_t   load;
    screen_pos_t pos;
    rgb_t        rgb;

    logic [IDXW-1:0] bmp_model [BMP_PIXELS];  // reference copies
    rgb_t            pal_model [2**IDXW];
    int              frame_no;
    int              cycle_cnt = 0;
    int              line_len  = 0;  // scan timing counters
    int              line_cnt  = 0;
    int              hs_low    = 0;
    int              vs_low    = 0;

    display_top i_display_top (.clk_pix, .rst, .load, .pos, .rgb);

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_pix);
        #1;
        if (!rst && pos.sx == '0 && pos.sy == '0) begin
            frame_no++;
        end
    endtask

    task automatic check_reset_state();
        check_value("pos.sx", pos.sx, 0);
        check_value("pos.sy", pos.sy, 0);
        check_value("pos.hsync", pos.hsync, 1);
        check_value("pos.vsync", pos.vsync, 1);
        check_value("pos.de", pos.de, 0);
        check_value("rgb", rgb, 0);
        check_value("evt", i_display_top.evt, 0);  // both strobes low
        check_value("lb_we", i_display_top.lb_we, 0);
    endtask

    // palette first, then every bitmap index, one word per cycle
    task automatic load_image();
        logic [31:0] word;
        for (int n = 0; n < 2**IDXW; n++) begin
            word             = $urandom;
            pal_model[n]     = word[11:0];
            load.valid       = 1'b1;
            load.sel_palette = 1'b1;
            load.addr        = BMP_ADDRW'(n);
            load.data        = word[11:0];
            next_cycle();
        end
        for (int n = 0; n < BMP_PIXELS; n++) begin
            word             = $urandom;
            bmp_model[n]     = word[IDXW-1:0];
            load.sel_palette = 1'b0;
            load.addr        = BMP_ADDRW'(n);
            load.data        = word[11:0];  // upper bits are junk on purpose
            next_cycle();
        end
        load.valid = 1'b0;
    endtask

    // changes the colour of the top left pixel's index
    task automatic rewrite_palette();
        logic [IDXW-1:0] entry;
        rgb_t            new_colour;
        entry            = bmp_model[0];
        new_colour       = pal_model[entry] ^ 12'hfff;
        load.valid       = 1'b1;
        load.sel_palette = 1'b1;
        load.addr        = BMP_ADDRW'(entry);
        load.data        = new_colour;
        next_cycle();
        load.valid       = 1'b0;
        pal_model[entry] = new_colour;
    endtask

    // black outside the visible area, else palette of the scaled bitmap pixel
    function automatic rgb_t expected_rgb(input int x, input int y);
        if (x >= H_RES || y >= V_RES) begin
            return '0;
        end
        return pal_model[bmp_model[(y / SCALE) * BMP_W + x / SCALE]];
    endfunction

    task automatic wait_for_point(input probe_t p);
        while (!(frame_no == p.frame && pos.sx == p.sx && pos.sy == p.sy)) begin
            next_cycle();
        end
    endtask

    initial begin
        rgb_t expected;
        rgb_t prev;
        void'($urandom(71));
        rst      = 1'b1;
        load     = '0;
        frame_no = 0;
        prev     = '0;
        repeat (4) begin
            next_cycle();
            check_reset_state();
        end
        rst = 1'b0;
        next_cycle();
        check_value("pos.sx", pos.sx, 1);  // counters left 0,0
        check_value("pos.sy", pos.sy, 0);
        check_value("pos.hsync", pos.hsync, 1);
        check_value("pos.vsync", pos.vsync, 1);
        frame_no = 1;
        load_image();
        for (int i = 0; i < N_PROBES; i++) begin
            wait_for_point(PROBES[i]);
            if (PROBES[i].rewrite) begin
                rewrite_palette();
            end else begin
                check_value("pos.de", pos.de,
                            (PROBES[i].sx < H_RES) && (PROBES[i].sy < V_RES));
                if (PROBES[i].pair) begin
                    check_value("rgb of scaled pair", rgb, prev);  // copy of the probe before
                end else begin
                    expected = expected_rgb(PROBES[i].sx, PROBES[i].sy);
                    check_value("rgb", rgb, expected);
                end
                prev = rgb;
            end
        end
        if (i_display_top.i_timing.i_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // line and frame lengths counted from pos, mid cycle
    always @(negedge clk_pix) begin
        if (!rst) begin
            line_len++;
            hs_low += !pos.hsync;
            vs_low += !pos.vsync;
            if (pos.sx == CORDW'(H_TOTAL - 1)) begin
                line_cnt++;
                check_value("line length", line_len, H_TOTAL);
                check_value("hsync low cycles", hs_low, H_SYNC);
                line_len = 0;
                hs_low   = 0;
                if (pos.sy == CORDW'(V_TOTAL - 1)) begin
                    check_value("lines per frame", line_cnt, V_TOTAL);
                    check_value("vsync low cycles", vs_low, V_SYNC * H_TOTAL);
                    line_cnt = 0;
                    vs_low   = 0;
                end
            end
        end
    end

    // three frames plus the load plus margin
    always @(posedge clk_pix) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1);
        end else if (i_display_top.i_timing.i_asserts.fail_count != 0) begin
            $display("a concurrent assertion on the scan timing failed");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- project.f
design/display_pkg.sv
design/display_timing.sv
design/bitmap_store.sv
design/colour_lut.sv
design/line_fetch.sv
design/line_buffer.sv
design/display_top.sv
sim/display_asserts.sv
sim/display_tb.sv
